//--- source/scratch_queue_defs.svh
`ifndef SCRATCH_QUEUE_DEFS_SVH
`define SCRATCH_QUEUE_DEFS_SVH

// Scratchpad address width, 64 words
`define SQ_ADDR_W 6

// Scratchpad data word width
`define SQ_DATA_W 16

// Read tag width, upper bits of the read payload
`define SQ_TAG_W 8

// Command FIFO depth, holds DEPTH-1 entries
`define SQ_CMD_DEPTH 4

// Response FIFO depth, holds DEPTH-1 entries
`define SQ_RSP_DEPTH 4

`endif

//--- source/scratch_queue_pkg.sv
`include "scratch_queue_defs.svh"

package scratch_queue_pkg;

    // Command opcode
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

    // Read view of the payload
    // Tag on top, rest reserved
    typedef struct packed {
        logic [`SQ_TAG_W-1:0]            tag;
        logic [`SQ_DATA_W-`SQ_TAG_W-1:0] rsvd;
    } rd_payload_t;

    // Same 16 bits, decoded per opcode
    typedef union packed {
        logic [`SQ_DATA_W-1:0] wr_data;
        rd_payload_t           rd;
    } cmd_payload_u;

    // One queued command, 23 bits
    typedef struct packed {
        op_e                   op;
        logic [`SQ_ADDR_W-1:0] addr;
        cmd_payload_u          payload;
    } cmd_t;

    // One read response, 24 bits
    typedef struct packed {
        logic [`SQ_TAG_W-1:0]  tag;
        logic [`SQ_DATA_W-1:0] data;
    } rsp_t;

endpackage : scratch_queue_pkg

//--- source/fifo_if.sv
`include "scratch_queue_defs.svh"

interface fifo_if #(
    parameter int DWIDTH = `SQ_DATA_W
) ();

    // Push side, write lands one edge later
    logic              push;
    logic              full;
    logic [DWIDTH-1:0] wdata;

    // Pop side, head visible combinationally
    logic              pop;
    logic              empty;
    logic [DWIDTH-1:0] rdata;

    // Seen from the FIFO itself
    modport fifo (
        input  push,
        input  wdata,
        input  pop,
        output full,
        output empty,
        output rdata
    );

    // Seen from whoever pushes or pops
    modport user (
        output push,
        output wdata,
        output pop,
        input  full,
        input  empty,
        input  rdata
    );

endinterface : fifo_if

//--- source/fifo_0r1w.sv
`include "scratch_queue_defs.svh"

module fifo_0r1w #(
    parameter int DWIDTH = `SQ_DATA_W,
    parameter int DEPTH  = `SQ_CMD_DEPTH
) (
    input logic  i_clk,
    input logic  i_rst_n,
    fifo_if.fifo i_bus
);

    // Pointer width, at least one bit
    localparam int AWIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Entry storage
    logic [DEPTH-1:0][DWIDTH-1:0] mem;

    // Wrap-around pointers
    logic [AWIDTH-1:0] push_idx;
    logic [AWIDTH-1:0] pop_idx;
    logic [AWIDTH-1:0] next_push_idx;
    logic [AWIDTH-1:0] next_pop_idx;

    // Next pointer values, wrap at DEPTH-1
    // Works for any depth, not only powers of two
    always_comb begin
        next_push_idx = (push_idx == AWIDTH'(DEPTH - 1)) ? '0 : push_idx + AWIDTH'(1);
        next_pop_idx  = (pop_idx == AWIDTH'(DEPTH - 1)) ? '0 : pop_idx + AWIDTH'(1);
    end

    // One slot kept free to tell full from empty
    assign i_bus.full  = (next_push_idx == pop_idx);
    assign i_bus.empty = (push_idx == pop_idx);

    // Output mux, zero-cycle read of the head
    assign i_bus.rdata = mem[pop_idx];

    // Pointer update
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            push_idx <= '0;
            pop_idx  <= '0;
        end else begin
            if (i_bus.push) begin
                push_idx <= next_push_idx;
            end
            if (i_bus.pop) begin
                pop_idx <= next_pop_idx;
            end
        end
    end

    // Input demux, entry lands at the push edge
    always_ff @(posedge i_clk) begin
        if (i_bus.push) begin
            mem[push_idx] <= i_bus.wdata;
        end
    end

    // Producer must respect the full level
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_bus.push && i_bus.full));

    // Consumer must respect the empty level
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_bus.pop && i_bus.empty));

    // Pointers stay inside the array
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (int'(push_idx) < DEPTH) && (int'(pop_idx) < DEPTH));

endmodule : fifo_0r1w

//--- source/scratch_engine.sv
`include "scratch_queue_defs.svh"

module scratch_engine (
    input logic  i_clk,
    input logic  i_rst_n,
    fifo_if.user i_cmd,
    fifo_if.user o_rsp
);

    // Scratchpad, contents undefined until written
    logic [`SQ_DATA_W-1:0] spad [1 << `SQ_ADDR_W];

    // Head of the command queue
    scratch_queue_pkg::cmd_t head;

    // Response built from the head
    scratch_queue_pkg::rsp_t rsp;

    logic is_read;
    logic retire;

    // Head command straight off the FIFO output mux
    assign head = i_cmd.rdata;

    assign is_read = (head.op == scratch_queue_pkg::OP_READ);

    // Writes always retire
    // Reads need a free response slot
    assign retire = !i_cmd.empty && (!is_read || !o_rsp.full);

    // One command per cycle
    assign i_cmd.pop = retire;

    // Read path
    // Tag from the read view of the union
    // Data from the combinational scratchpad word
    always_comb begin
        rsp.tag  = head.payload.rd.tag;
        rsp.data = spad[head.addr];
    end

    // Response pushed at the same edge as the pop
    assign o_rsp.push  = retire && is_read;
    assign o_rsp.wdata = rsp;

    // Write path, data from the write view of the union
    // Lands at the pop edge, so later reads see it
    always_ff @(posedge i_clk) begin
        if (retire && !is_read) begin
            spad[head.addr] <= head.payload.wr_data;
        end
    end

    // A stalled read must never overflow the response queue
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rsp.push |-> !o_rsp.full);

    // Engine only retires what the command queue holds
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd.pop |-> !i_cmd.empty);

endmodule : scratch_engine

//--- source/scratch_queue.sv
`include "scratch_queue_defs.svh"

module scratch_queue (
    input  logic                       i_clk,
    input  logic                       i_rst_n,

    // Request side
    input  logic                       i_req_push,
    input  scratch_queue_pkg::op_e     i_req_op,
    input  logic [`SQ_ADDR_W-1:0]      i_req_addr,
    input  logic [`SQ_DATA_W-1:0]      i_req_payload,
    output logic                       o_req_full,

    // Response side
    input  logic                       i_rsp_pop,
    output logic                       o_rsp_empty,
    output logic [`SQ_TAG_W-1:0]       o_rsp_tag,
    output logic [`SQ_DATA_W-1:0]      o_rsp_data
);

    // Packed request and unpacked response
    scratch_queue_pkg::cmd_t req_cmd;
    scratch_queue_pkg::rsp_t rsp_word;

    // Queue buses
    fifo_if #(.DWIDTH($bits(scratch_queue_pkg::cmd_t))) cmd_bus ();
    fifo_if #(.DWIDTH($bits(scratch_queue_pkg::rsp_t))) rsp_bus ();

    // Raw payload goes in undecoded
    assign req_cmd = {i_req_op, i_req_addr, i_req_payload};

    // Agent pushes commands
    assign cmd_bus.push  = i_req_push;
    assign cmd_bus.wdata = req_cmd;
    assign o_req_full    = cmd_bus.full;

    // Agent drains responses
    assign rsp_bus.pop  = i_rsp_pop;
    assign o_rsp_empty  = rsp_bus.empty;
    assign rsp_word     = rsp_bus.rdata;
    assign o_rsp_tag    = rsp_word.tag;
    assign o_rsp_data   = rsp_word.data;

    fifo_0r1w #(
        .DWIDTH ($bits(scratch_queue_pkg::cmd_t)),
        .DEPTH  (`SQ_CMD_DEPTH)
    ) u_cmd_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_bus   (cmd_bus.fifo)
    );

    fifo_0r1w #(
        .DWIDTH ($bits(scratch_queue_pkg::rsp_t)),
        .DEPTH  (`SQ_RSP_DEPTH)
    ) u_rsp_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_bus   (rsp_bus.fifo)
    );

    scratch_engine u_engine (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (cmd_bus.user),
        .o_rsp   (rsp_bus.user)
    );

endmodule : scratch_queue

//--- tb/scratch_queue_tb.sv
`include "scratch_queue_defs.svh"

module scratch_queue_tb;

    localparam int CLK_PERIOD = 4;
    localparam int WAIT_LIMIT = 64;
    localparam int RAND_STEPS = 200;

    // Cycle budget for each test
    localparam int BUDGET_RESET    = 12;
    localparam int BUDGET_WR_RD    = 20;
    localparam int BUDGET_IN_ORDER = 80;
    localparam int BUDGET_BACK_PR  = 60;
    localparam int BUDGET_RANDOM   = RAND_STEPS * 3 + 40;
    localparam int WATCHDOG_CYCLES = BUDGET_RESET + BUDGET_WR_RD + BUDGET_IN_ORDER
                                   + BUDGET_BACK_PR + BUDGET_RANDOM + 100;

    logic                   clk;
    logic                   rst_n;
    logic                   req_push;
    scratch_queue_pkg::op_e req_op;
    logic [`SQ_ADDR_W-1:0]  req_addr;
    logic [`SQ_DATA_W-1:0]  req_payload;
    logic                   req_full;
    logic                   rsp_pop;
    logic                   rsp_empty;
    logic [`SQ_TAG_W-1:0]   rsp_tag;
    logic [`SQ_DATA_W-1:0]  rsp_data;

    // Scratchpad model and which words hold known data
    logic [`SQ_DATA_W-1:0] model [1 << `SQ_ADDR_W];
    bit                    written [1 << `SQ_ADDR_W];

    // Responses still owed in issue order
    scratch_queue_pkg::rsp_t exp_q [$];

    logic [31:0] lcg_state = 32'h578b_24d0;

    scratch_queue i_dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_req_push    (req_push),
        .i_req_op      (req_op),
        .i_req_addr    (req_addr),
        .i_req_payload (req_payload),
        .o_req_full    (req_full),
        .i_rsp_pop     (rsp_pop),
        .o_rsp_empty   (rsp_empty),
        .o_rsp_tag     (rsp_tag),
        .o_rsp_data    (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("timeout, the tests did not finish within the cycle budget");
    end

    // Numerical Recipes constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_rsp(input string test, input scratch_queue_pkg::rsp_t expected,
                               input scratch_queue_pkg::rsp_t actual);
        if (actual !== expected) begin
            report_failure($sformatf(
                "mismatch %s: expected tag=%02h data=%04h, actual tag=%02h data=%04h",
                test, expected.tag, expected.data, actual.tag, actual.data));
        end
    endtask

    task automatic compare_flag(input string test, input string name, input logic expected,
                                input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: %s expected %0b, actual %0b",
                test, name, expected, actual));
        end
    endtask

    // Strobes stay high for exactly one edge
    task automatic drive_cycle(input logic push, input scratch_queue_pkg::cmd_t cmd,
                               input logic pop);
        @(posedge clk);
        req_push    <= push;
        req_op      <= cmd.op;
        req_addr    <= cmd.addr;
        req_payload <= cmd.payload;
        rsp_pop     <= pop;
        @(posedge clk);
        req_push    <= 1'b0;
        rsp_pop     <= 1'b0;
    endtask

    // Levels sampled mid-cycle
    task automatic wait_not_full(input string test);
        int waited = 0;
        @(negedge clk);
        while (req_full) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure($sformatf("%s: command queue never left the full state", test));
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_not_empty(input string test);
        int waited = 0;
        @(negedge clk);
        while (rsp_empty) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure($sformatf("%s: no response arrived in time", test));
            end
            @(negedge clk);
        end
    endtask

    task automatic issue_write(input string test, input logic [`SQ_ADDR_W-1:0] addr,
                               input logic [`SQ_DATA_W-1:0] data);
        scratch_queue_pkg::cmd_t cmd;
        cmd                 = '0;
        cmd.op              = scratch_queue_pkg::OP_WRITE;
        cmd.addr            = addr;
        cmd.payload.wr_data = data;
        wait_not_full(test);
        drive_cycle(1'b1, cmd, 1'b0);
        model[addr]   = data;
        written[addr] = 1'b1;
    endtask

    // Expected data is the model word at issue time
    task automatic issue_read(input string test, input logic [`SQ_ADDR_W-1:0] addr,
                              input logic [`SQ_TAG_W-1:0] tag);
        scratch_queue_pkg::cmd_t cmd;
        scratch_queue_pkg::rsp_t expected;
        cmd                 = '0;
        cmd.op              = scratch_queue_pkg::OP_READ;
        cmd.addr            = addr;
        cmd.payload.rd.tag  = tag;
        expected.tag        = tag;
        expected.data       = model[addr];
        wait_not_full(test);
        drive_cycle(1'b1, cmd, 1'b0);
        exp_q.push_back(expected);
    endtask

    task automatic expect_next_rsp(input string test);
        scratch_queue_pkg::rsp_t actual;
        wait_not_empty(test);
        actual.tag  = rsp_tag;
        actual.data = rsp_data;
        if (exp_q.size() == 0) begin
            report_failure($sformatf("%s: response arrived with no read outstanding", test));
        end
        compare_rsp(test, exp_q.pop_front(), actual);
        drive_cycle(1'b0, '0, 1'b1);
    endtask

    task automatic check_idle(input string test);
        @(negedge clk);
        compare_flag(test, "o_req_full", 1'b0, req_full);
        compare_flag(test, "o_rsp_empty", 1'b1, rsp_empty);
    endtask

    task automatic reset_state();
        check_idle("reset_state");
    endtask

    task automatic write_then_read();
        issue_write("write_then_read", 6'd5, 16'(lcg_next() >> 16));
        issue_read("write_then_read", 6'd5, 8'ha5);
        expect_next_rsp("write_then_read");
        check_idle("write_then_read");
    endtask

    task automatic in_order_tags();
        for (int i = 0; i < 6; i++) begin
            issue_write("in_order_tags", 6'(i * 9 + 2), 16'(lcg_next() >> 16));
        end
        // Two batches of three since a queue holds at most three
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 3; i++) begin
                issue_read("in_order_tags", 6'((b * 3 + i) * 9 + 2), 8'(8'h40 + b * 3 + i));
            end
            repeat (3) expect_next_rsp("in_order_tags");
        end
        check_idle("in_order_tags");
    endtask

    // Three reads fill the response queue and three more stall in the command queue
    task automatic back_pressure();
        for (int i = 0; i < 6; i++) begin
            issue_read("back_pressure", 6'(i * 9 + 2), 8'(8'hc0 + i));
        end
        @(negedge clk);
        compare_flag("back_pressure", "o_req_full", 1'b1, req_full);
        compare_flag("back_pressure", "o_rsp_empty", 1'b0, rsp_empty);
        repeat (6) expect_next_rsp("back_pressure");
        check_idle("back_pressure");
    endtask

    task automatic random_mix();
        logic [31:0]                r;
        logic                       do_push;
        logic                       do_pop;
        logic [`SQ_ADDR_W-1:0]      addr;
        scratch_queue_pkg::cmd_t    cmd;
        scratch_queue_pkg::rsp_t    expected;
        scratch_queue_pkg::rsp_t    actual;
        for (int step = 0; step < RAND_STEPS; step++) begin
            @(negedge clk);
            r        = lcg_next();
            do_push  = !req_full && (r[1:0] != 2'd0);
            do_pop   = !rsp_empty && (r[4:3] != 2'd0);
            addr     = r[10:5];
            cmd      = '0;
            cmd.addr = addr;
            if (do_pop) begin
                actual.tag  = rsp_tag;
                actual.data = rsp_data;
                if (exp_q.size() == 0) begin
                    report_failure("random_mix: response arrived with no read outstanding");
                end
                compare_rsp("random_mix", exp_q.pop_front(), actual);
            end
            if (do_push) begin
                // Reads only hit words with known contents
                if (r[11] && written[addr]) begin
                    cmd.op              = scratch_queue_pkg::OP_READ;
                    cmd.payload.rd.tag  = r[19:12];
                    cmd.payload.rd.rsvd = r[27:20];
                    expected.tag        = r[19:12];
                    expected.data       = model[addr];
                    exp_q.push_back(expected);
                end else begin
                    cmd.op              = scratch_queue_pkg::OP_WRITE;
                    cmd.payload.wr_data = r[31:16];
                    model[addr]         = r[31:16];
                    written[addr]       = 1'b1;
                end
            end
            drive_cycle(do_push, cmd, do_pop);
        end
        // Drain what is still in flight
        while (exp_q.size() > 0) begin
            expect_next_rsp("random_mix");
        end
        check_idle("random_mix");
    endtask

    initial begin
        rst_n       = 1'b0;
        req_push    = 1'b0;
        req_op      = scratch_queue_pkg::OP_WRITE;
        req_addr    = '0;
        req_payload = '0;
        rsp_pop     = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        reset_state();
        write_then_read();
        in_order_tags();
        back_pressure();
        random_mix();

        $display("*** PASSED ***");
        $finish;
    end

endmodule : scratch_queue_tb

//--- scratch_queue.f
+incdir+source
source/scratch_queue_pkg.sv
source/fifo_if.sv
source/fifo_0r1w.sv
source/scratch_engine.sv
source/scratch_queue.sv
tb/scratch_queue_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the scratch queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module scratch_queue_tb \
    --Mdir obj_dir \
    -f scratch_queue.f
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vscratch_queue_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** PASSED ***" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
